//--- Makefile
TOP   := collision_detector_tb
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f compile.f --Mdir $(BUILD) -o sim
	./$(BUILD)/sim | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) && echo "Result: pass" || \
		(echo "Result: fail"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- compile.f
src/sat_pkg.sv
src/rect_corners.sv
src/sat_half_test.sv
src/collision_detector.sv
dv/collision_detector_chk.sv
dv/collision_detector_tb.sv

//--- dv/collision_detector_chk.sv
`default_nettype none

module collision_detector_chk (
    input logic             clk,
    input logic             reset,
    input logic             out_valid,
    input logic             out_ready,
    input sat_pkg::result_t out_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // A stalled result keeps its slot and its value
    a_hold_result: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("Output result changed or vanished while stalled");

    // Collision bit agrees with the separation mask
    a_collision_mask: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> out_data.collision == (out_data.sep_mask == 8'd0)
    ) else $error("Collision bit does not match an empty separation mask");

    a_reset_clear: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("out_valid high in the cycle after reset");

endmodule

bind collision_detector collision_detector_chk u_chk (.*);

`default_nettype wire

//--- dv/collision_detector_tb.sv
`default_nettype none

module collision_detector_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import sat_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int POS_FRAC    = 25;
    localparam int N_DIRECTED  = 4;
    localparam int N_RANDOM    = 300;
    localparam int N_BP        = 200;
    localparam int N_STREAM    = 40;
    localparam int TOTAL_TXNS  = N_DIRECTED + N_RANDOM + N_BP + N_STREAM;
    localparam int WATCHDOG_NS = TOTAL_TXNS * 20 * CLK_PERIOD;

    logic    clk = 1'b0;
    logic    reset;
    logic    in_valid;
    logic    in_ready;
    pair_t   in_data;
    logic    out_valid;
    logic    out_ready;
    result_t out_data;

    logic [15:0] lfsr = 16'd54232;
    longint      cycle_count = 0;
    int          error_count = 0;
    string       test_name = "reset";
    bit          bp_mode = 1'b0;
    bit          stream_mode = 1'b0;
    bit          latency_mode = 1'b0;
    bit          ready_high = 1'b0;

    result_t exp_q[$];
    longint  acc_q[$];
    pair_t   rand_pairs [N_RANDOM];
    pair_t   bp_pairs [N_BP];
    pair_t   stream_pairs [N_STREAM];

    collision_detector u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // 16-bit Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    // Keep the low w bits of v as a signed number
    function automatic longint wrap(input longint v, input int w);
        return (v <<< (64 - w)) >>> (64 - w);
    endfunction

    function automatic logic [31:0] unit_pos(input int n);
        return 32'(n) <<< POS_FRAC;
    endfunction

    // Axis-aligned rectangle turned by rot quarter turns
    function automatic rect_t make_rect(input int w, input int h, input logic [31:0] px,
                                        input logic [31:0] py, input logic [1:0] rot);
        rect_t r;
        r.width  = SIZE_W'(w);
        r.height = SIZE_W'(h);
        r.pos_x  = px;
        r.pos_y  = py;
        case (rot)
            2'd0: begin
                r.u = '{x: UNIT_ONE, y: 16'sd0};
                r.v = '{x: 16'sd0, y: UNIT_ONE};
            end
            2'd1: begin
                r.u = '{x: 16'sd0, y: UNIT_ONE};
                r.v = '{x: -UNIT_ONE, y: 16'sd0};
            end
            2'd2: begin
                r.u = '{x: -UNIT_ONE, y: 16'sd0};
                r.v = '{x: 16'sd0, y: -UNIT_ONE};
            end
            default: begin
                r.u = '{x: 16'sd0, y: -UNIT_ONE};
                r.v = '{x: UNIT_ONE, y: 16'sd0};
            end
        endcase
        return r;
    endfunction

    function automatic rect_t random_rect();
        int          w;
        int          h;
        logic [31:0] px;
        logic [31:0] py;
        logic [1:0]  rot;
        rect_t       r;
        w   = int'(rand_bits(7) % 127) + 1;
        h   = int'(rand_bits(7) % 127) + 1;
        px  = rand_bits(32);
        py  = rand_bits(32);
        rot = 2'(rand_bits(2));
        r   = make_rect(w, h, px, py, rot);
        // About half get an arbitrary basis
        if (rand_bits(1) != 0) begin
            r.u.x = 16'(rand_bits(16));
            r.u.y = 16'(rand_bits(16));
            r.v.x = 16'(rand_bits(16));
            r.v.y = 16'(rand_bits(16));
        end
        return r;
    endfunction

    function automatic pair_t random_pair();
        pair_t p;
        p.a = random_rect();
        p.b = random_rect();
        return p;
    endfunction

    // Separation flags for src's corners against the axes of rectangle axes
    function automatic logic [3:0] model_sep(input rect_t src, input rect_t axes);
        longint     cx, cy, ox, oy;
        longint     hw, hh, aw, ah, sw, sh;
        longint     px, py, rx, ry, pu, pv;
        longint     min_u, max_u, min_v, max_v;
        longint     lim_w, lim_h;
        logic [3:0] sep;
        cx = wrap(longint'(src.pos_x) >>> POS_SHIFT, CORNER_W);
        cy = wrap(longint'(src.pos_y) >>> POS_SHIFT, CORNER_W);
        ox = wrap(longint'(axes.pos_x) >>> POS_SHIFT, CORNER_W);
        oy = wrap(longint'(axes.pos_y) >>> POS_SHIFT, CORNER_W);
        hw = longint'(src.width) >>> 1;
        hh = longint'(src.height) >>> 1;
        aw = longint'(axes.width) >>> 1;
        ah = longint'(axes.height) >>> 1;
        for (int i = 0; i < NUM_CORNERS; i++) begin
            sw = (i >= 2) ? hw : -hw;
            sh = (i % 2 == 1) ? hh : -hh;
            px = wrap(sw * longint'(src.u.x) + sh * longint'(src.v.x) + cx, CORNER_W);
            py = wrap(sw * longint'(src.u.y) + sh * longint'(src.v.y) + cy, CORNER_W);
            rx = wrap(px - ox, CORNER_W);
            ry = wrap(py - oy, CORNER_W);
            pu = wrap(rx * longint'(axes.u.x) + ry * longint'(axes.u.y), DOT_W);
            pv = wrap(rx * longint'(axes.v.x) + ry * longint'(axes.v.y), DOT_W);
            pu = wrap(pu >>> PROJ_SHIFT, EXTENT_W);
            pv = wrap(pv >>> PROJ_SHIFT, EXTENT_W);
            if (i == 0 || pu < min_u) min_u = pu;
            if (i == 0 || pu > max_u) max_u = pu;
            if (i == 0 || pv < min_v) min_v = pv;
            if (i == 0 || pv > max_v) max_v = pv;
        end
        lim_w  = wrap(aw <<< EXTENT_SHIFT, EXTENT_W);
        lim_h  = wrap(ah <<< EXTENT_SHIFT, EXTENT_W);
        sep[3] = (min_u >= lim_w);
        sep[2] = (max_u <= -lim_w);
        sep[1] = (min_v >= lim_h);
        sep[0] = (max_v <= -lim_h);
        return sep;
    endfunction

    function automatic result_t model_result(input pair_t p);
        result_t r;
        r.sep_mask  = {model_sep(p.b, p.a), model_sep(p.a, p.b)};
        r.collision = (r.sep_mask == 8'd0);
        return r;
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        if (expected != actual) begin
            error_count++;
            $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    // Holds the pair until it is taken; returns 1 ns after the accepting edge
    task automatic send_pair(input pair_t p);
        in_data  = p;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_rects(input rect_t a, input rect_t b);
        pair_t p;
        p.a = a;
        p.b = b;
        send_pair(p);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Ready stays low through reset and turns random in the back-pressure test
    always begin
        @(posedge clk);
        #1;
        if (bp_mode) out_ready = (rand_bits(1) != 0);
        else out_ready = ready_high;
    end

    // Scoreboard samples mid-cycle for the transfers at the next edge
    always @(negedge clk) begin : scoreboard
        bit      got_result;
        bit      had_expected;
        result_t exp;
        longint  acc;
        got_result   = !reset && out_valid && out_ready;
        had_expected = (exp_q.size() != 0);
        if (got_result && had_expected) begin
            exp = exp_q.pop_front();
            acc = acc_q.pop_front();
            check_value({test_name, " collision"}, exp.collision, out_data.collision);
            check_value({test_name, " sep_mask"}, exp.sep_mask, out_data.sep_mask);
            if (latency_mode) check_value({test_name, " latency"}, 3, cycle_count - acc);
        end
        if (!reset && in_valid && in_ready) begin
            exp_q.push_back(model_result(in_data));
            acc_q.push_back(cycle_count);
        end
        if (!reset && stream_mode && in_valid) check_value("stream in_ready", 1, in_ready);
        if (got_result && !had_expected) begin
            $display("Result delivered in test %s with no pair outstanding", test_name);
            $display("SOME TESTS FAILED");
            $fatal(1, "Unexpected result");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        for (int i = 0; i < N_RANDOM; i++) rand_pairs[i] = random_pair();
        for (int i = 0; i < N_BP; i++) bp_pairs[i] = random_pair();
        for (int i = 0; i < N_STREAM; i++) stream_pairs[i] = random_pair();

        repeat (4) begin
            @(posedge clk);
            #1;
            check_value("reset out_valid", 0, out_valid);
            check_value("reset in_ready", 1, in_ready);
        end
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_value("after reset out_valid", 0, out_valid);
        check_value("after reset in_ready", 1, in_ready);

        // Output side takes results from here on
        @(negedge clk);
        ready_high = 1'b1;
        @(posedge clk);
        #1;

        // Overlap, edge contact, apart in x, apart in y
        test_name = "directed";
        send_rects(make_rect(10, 10, unit_pos(0), unit_pos(0), 2'd0),
                   make_rect(10, 10, unit_pos(3), unit_pos(3), 2'd1));
        send_rects(make_rect(10, 10, unit_pos(0), unit_pos(0), 2'd0),
                   make_rect(10, 10, unit_pos(10), unit_pos(0), 2'd0));
        send_rects(make_rect(20, 8, unit_pos(0), unit_pos(0), 2'd2),
                   make_rect(6, 6, unit_pos(40), unit_pos(2), 2'd0));
        send_rects(make_rect(8, 20, unit_pos(5), unit_pos(0), 2'd0),
                   make_rect(6, 6, unit_pos(5), unit_pos(-40), 2'd3));
        drain();

        test_name = "random";
        foreach (rand_pairs[i]) send_pair(rand_pairs[i]);
        drain();

        test_name = "backpressure";
        @(negedge clk);
        bp_mode = 1'b1;
        @(posedge clk);
        #1;
        foreach (bp_pairs[i]) send_pair(bp_pairs[i]);
        drain();
        @(negedge clk);
        bp_mode = 1'b0;
        @(posedge clk);
        #1;

        test_name    = "stream";
        stream_mode  = 1'b1;
        latency_mode = 1'b1;
        foreach (stream_pairs[i]) send_pair(stream_pairs[i]);
        stream_mode = 1'b0;
        drain();
        latency_mode = 1'b0;

        // Any stray result shows up here
        repeat (5) @(posedge clk);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/collision_detector.sv
`default_nettype none

module collision_detector (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  sat_pkg::pair_t   in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output sat_pkg::result_t out_data
);

    import sat_pkg::*;

    logic     advance;
    logic     s1_valid;
    logic     s2_valid;

    corners_t corners_a;
    corners_t corners_b;
    corners_t corners_a_q;
    corners_t corners_b_q;
    rect_t    rect_a_q;
    rect_t    rect_b_q;

    sep_t     sep_a_on_b;
    sep_t     sep_b_on_a;
    logic [7:0] sep_mask;

    // Whole pipeline steps together when the output slot frees up
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    rect_corners u_corners_a (
        .rect    (in_data.a),
        .corners (corners_a)
    );

    rect_corners u_corners_b (
        .rect    (in_data.b),
        .corners (corners_b)
    );

    // Stage 1
    always_ff @(posedge clk) begin
        if (advance) begin
            corners_a_q <= corners_a;
            corners_b_q <= corners_b;
            rect_a_q    <= in_data.a;
            rect_b_q    <= in_data.b;
        end
    end

    // Stage 2 lives inside the half-tests
    sat_half_test u_test_a_on_b (
        .clk       (clk),
        .reset     (reset),
        .enable    (advance),
        .corners   (corners_a_q),
        .axes_rect (rect_b_q),
        .sep       (sep_a_on_b)
    );

    sat_half_test u_test_b_on_a (
        .clk       (clk),
        .reset     (reset),
        .enable    (advance),
        .corners   (corners_b_q),
        .axes_rect (rect_a_q),
        .sep       (sep_b_on_a)
    );

    assign sep_mask = {sep_b_on_a, sep_a_on_b};

    // Stage 3 flags a collision only when no axis separates
    always_ff @(posedge clk) begin
        if (advance) begin
            out_data.collision <= (sep_mask == 8'd0);
            out_data.sep_mask  <= sep_mask;
        end
    end

endmodule

`default_nettype wire

//--- src/rect_corners.sv
`default_nettype none

module rect_corners (
    input  sat_pkg::rect_t    rect,
    output sat_pkg::corners_t corners
);

    import sat_pkg::*;

    logic signed [SIZE_W-1:0]   half_w;
    logic signed [SIZE_W-1:0]   half_h;
    logic signed [SIZE_W-1:0]   neg_half_w;
    logic signed [SIZE_W-1:0]   neg_half_h;
    logic signed [CORNER_W-1:0] center_x;
    logic signed [CORNER_W-1:0] center_y;

    // Half sizes in whole units
    assign half_w = rect.width >>> 1;
    assign half_h = rect.height >>> 1;

    assign neg_half_w = -half_w;
    assign neg_half_h = -half_h;

    // Position moved from 25 to 14 fraction bits to line up with the basis products
    assign center_x = CORNER_W'(rect.pos_x >>> POS_SHIFT);
    assign center_y = CORNER_W'(rect.pos_y >>> POS_SHIFT);

    for (genvar i = 0; i < NUM_CORNERS; i++) begin : g_corner
        // Corners 2 and 3 sit on the +w side, corners 1 and 3 on the +h side
        localparam bit PLUS_W = (i >= 2);
        localparam bit PLUS_H = ((i % 2) == 1);

        logic signed [SIZE_W-1:0]   sel_w;
        logic signed [SIZE_W-1:0]   sel_h;
        logic signed [CORNER_W-1:0] off_x;
        logic signed [CORNER_W-1:0] off_y;

        assign sel_w = PLUS_W ? half_w : neg_half_w;
        assign sel_h = PLUS_H ? half_h : neg_half_h;

        // Rotate the local offset into world space
        assign off_x = sel_w * rect.u.x + sel_h * rect.v.x;
        assign off_y = sel_w * rect.u.y + sel_h * rect.v.y;

        assign corners.pt[i].x = off_x + center_x;
        assign corners.pt[i].y = off_y + center_y;
    end

endmodule

`default_nettype wire

//--- src/sat_half_test.sv
`default_nettype none

module sat_half_test (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  sat_pkg::corners_t corners,
    input  sat_pkg::rect_t    axes_rect,
    output sat_pkg::sep_t     sep
);

    import sat_pkg::*;

    logic signed [CORNER_W-1:0] org_x;
    logic signed [CORNER_W-1:0] org_y;
    logic signed [SIZE_W-1:0]   half_w;
    logic signed [SIZE_W-1:0]   half_h;

    logic signed [EXTENT_W-1:0] proj_u [NUM_CORNERS];
    logic signed [EXTENT_W-1:0] proj_v [NUM_CORNERS];

    extent_t                    extent_d;
    extent_t                    extent_q;
    logic signed [SIZE_W-1:0]   half_w_q;
    logic signed [SIZE_W-1:0]   half_h_q;

    logic signed [EXTENT_W-1:0] lim_w;
    logic signed [EXTENT_W-1:0] lim_h;

    // Origin of the axes rectangle in corner format
    assign org_x = CORNER_W'(axes_rect.pos_x >>> POS_SHIFT);
    assign org_y = CORNER_W'(axes_rect.pos_y >>> POS_SHIFT);

    assign half_w = axes_rect.width >>> 1;
    assign half_h = axes_rect.height >>> 1;

    for (genvar i = 0; i < NUM_CORNERS; i++) begin : g_proj
        logic signed [CORNER_W-1:0] rel_x;
        logic signed [CORNER_W-1:0] rel_y;
        logic signed [DOT_W-1:0]    dot_u;
        logic signed [DOT_W-1:0]    dot_v;

        // Corner relative to the axes rectangle
        assign rel_x = corners.pt[i].x - org_x;
        assign rel_y = corners.pt[i].y - org_y;

        // 14 + 14 fraction bits in the product
        assign dot_u = rel_x * axes_rect.u.x + rel_y * axes_rect.u.y;
        assign dot_v = rel_x * axes_rect.v.x + rel_y * axes_rect.v.y;

        assign proj_u[i] = EXTENT_W'(dot_u >>> PROJ_SHIFT);
        assign proj_v[i] = EXTENT_W'(dot_v >>> PROJ_SHIFT);
    end

    // Four-corner extents on each axis
    always_comb begin
        extent_d.min_u = proj_u[0];
        extent_d.max_u = proj_u[0];
        extent_d.min_v = proj_v[0];
        extent_d.max_v = proj_v[0];
        for (int i = 1; i < NUM_CORNERS; i++) begin
            if (proj_u[i] < extent_d.min_u) begin
                extent_d.min_u = proj_u[i];
            end
            if (proj_u[i] > extent_d.max_u) begin
                extent_d.max_u = proj_u[i];
            end
            if (proj_v[i] < extent_d.min_v) begin
                extent_d.min_v = proj_v[i];
            end
            if (proj_v[i] > extent_d.max_v) begin
                extent_d.max_v = proj_v[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            extent_q <= '0;
            half_w_q <= '0;
            half_h_q <= '0;
        end else if (enable) begin
            extent_q <= extent_d;
            half_w_q <= half_w;
            half_h_q <= half_h;
        end
    end

    // Half-sizes in extent format
    assign lim_w = EXTENT_W'(half_w_q) << EXTENT_SHIFT;
    assign lim_h = EXTENT_W'(half_h_q) << EXTENT_SHIFT;

    // Touching edges count as separated
    always_comb begin
        sep.min_u = (extent_q.min_u >= lim_w);
        sep.max_u = (extent_q.max_u <= -lim_w);
        sep.min_v = (extent_q.min_v >= lim_h);
        sep.max_v = (extent_q.max_v <= -lim_h);
    end

endmodule

`default_nettype wire

//--- src/sat_pkg.sv
`default_nettype none

package sat_pkg;

    // Field widths of the fixed-point formats
    localparam int SIZE_W      = 8;
    localparam int POS_W       = 32;
    localparam int BASIS_W     = 16;
    localparam int CORNER_W    = 21;
    localparam int DOT_W       = 35;
    localparam int EXTENT_W    = 32;
    localparam int NUM_CORNERS = 4;

    // Position carries 25 fraction bits, corners 14, extents 25 again
    localparam int POS_SHIFT    = 11;
    localparam int PROJ_SHIFT   = 3;
    localparam int EXTENT_SHIFT = 25;

    // 1.0 in the basis format with 14 fraction bits
    localparam logic signed [BASIS_W-1:0] UNIT_ONE = 16'sd16384;

    typedef struct packed {
        logic signed [BASIS_W-1:0] x;
        logic signed [BASIS_W-1:0] y;
    } vec2_t;

    typedef struct packed {
        logic signed [SIZE_W-1:0] width;
        logic signed [SIZE_W-1:0] height;
        logic signed [POS_W-1:0]  pos_x;
        logic signed [POS_W-1:0]  pos_y;
        vec2_t                    u;
        vec2_t                    v;
    } rect_t;

    // Input payload with one pair of rectangles
    typedef struct packed {
        rect_t a;
        rect_t b;
    } pair_t;

    typedef struct packed {
        logic signed [CORNER_W-1:0] x;
        logic signed [CORNER_W-1:0] y;
    } point_t;

    // pt[0] (-w,-h), pt[1] (-w,+h), pt[2] (+w,-h), pt[3] (+w,+h)
    typedef struct packed {
        point_t [NUM_CORNERS-1:0] pt;
    } corners_t;

    typedef struct packed {
        logic signed [EXTENT_W-1:0] min_u;
        logic signed [EXTENT_W-1:0] max_u;
        logic signed [EXTENT_W-1:0] min_v;
        logic signed [EXTENT_W-1:0] max_v;
    } extent_t;

    typedef struct packed {
        logic min_u;
        logic max_u;
        logic min_v;
        logic max_v;
    } sep_t;

    // sep_mask[3:0] from A onto B, sep_mask[7:4] from B onto A
    typedef struct packed {
        logic       collision;
        logic [7:0] sep_mask;
    } result_t;

endpackage

`default_nettype wire
